//--- Bender.yml
package:
  name: scratchpad_reader

sources:
  - common/dma_cfg_pkg.sv
  - common/spm_pkg.sv
  - accel_rd_dma/rr_arbiter.sv
  - accel_rd_dma/line_fifo.sv
  - accel_rd_dma/accel_rd_dma.sv
  - src/dual_bank_sram.sv
  - src/desc_regs.sv
  - src/scratchpad_reader.sv
  - target: test
    files:
      - test/tb_scratchpad_reader.sv

//--- accel_rd_dma/accel_rd_dma.sv
`timescale 1ns/100ps

module accel_rd_dma
  import dma_cfg_pkg::*, spm_pkg::*;
#(
  parameter int  ACCEL_COUNT = 4,
  parameter int  FIFO_LINES  = 2,
  localparam int ID_WIDTH    = (ACCEL_COUNT > 1) ? $clog2(ACCEL_COUNT) : 1
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic [ID_WIDTH-1:0]      desc_accel_id,
  input  byte_addr_t               desc_addr,
  input  len_t                     desc_len,
  input  logic                     desc_valid,
  output logic [ACCEL_COUNT-1:0]   accel_busy,

  output bank_addr_t               b1_rd_addr,
  output logic                     b1_rd_en,
  input  line_t                    b1_rd_data,
  output bank_addr_t               b2_rd_addr,
  output logic                     b2_rd_en,
  input  line_t                    b2_rd_data,

  output logic [ACCEL_COUNT*8-1:0] m_tdata,
  output logic [ACCEL_COUNT-1:0]   m_tlast,
  output logic [ACCEL_COUNT-1:0]   m_tvalid,
  input  logic [ACCEL_COUNT-1:0]   m_tready,
  input  logic [ACCEL_COUNT-1:0]   m_stop
);

  localparam int LINE_MSB   = ADDR_WIDTH - MASK_BITS - 1;
  localparam int META_WIDTH = 1 + 2 * MASK_BITS + 1 + ID_WIDTH;
  localparam int CNT_WIDTH  = $clog2(FIFO_LINES + 1);

  line_addr_t             req_addr;
  byte_ptr_t              req_offset;
  byte_ptr_t              req_final_ptr;
  line_cnt_t              req_count;
  logic [ID_WIDTH-1:0]    req_dest;
  logic [ACCEL_COUNT-1:0] req_onehot;
  logic                   req_v;
  logic                   req_last;
  line_cnt_t              desc_lines;

  line_addr_t             act_addr      [ACCEL_COUNT];
  line_cnt_t              act_count     [ACCEL_COUNT];
  byte_ptr_t              act_final_ptr [ACCEL_COUNT];
  byte_ptr_t              act_offset    [ACCEL_COUNT];
  logic [ACCEL_COUNT-1:0] act_v;
  logic                   act_last;

  logic [ACCEL_COUNT-1:0] stop_r;
  logic [ACCEL_COUNT-1:0] credit_ok;
  logic [ACCEL_COUNT-1:0] done;
  logic [ACCEL_COUNT-1:0] arb_request;
  logic [ACCEL_COUNT-1:0] arb_grant;
  logic [ID_WIDTH-1:0]    arb_enc;
  logic                   arb_valid;

  line_addr_t             rd_line;
  line_addr_t             rd_line_n;
  byte_ptr_t              req_ptr;
  byte_ptr_t              act_ptr;
  logic [META_WIDTH-1:0]  meta_s [4];
  logic [3:1]             vld_s;

  line_t                  b1_q;
  line_t                  b2_q;
  line_t                  line_s3;
  logic [2*DATA_WIDTH-1:0] pair_shifted;
  byte_ptr_t              s2_offset;
  logic                   s2_bank;
  logic                   s3_last;
  byte_ptr_t              s3_ptr;
  logic [ID_WIDTH-1:0]    s3_dest;

  // Partial final line rounds the line count up
  assign desc_lines = {1'b0, desc_len[LEN_WIDTH-1:MASK_BITS]};

  always_ff @(posedge clk) begin
    req_addr      <= desc_addr[ADDR_WIDTH-1:MASK_BITS];
    req_offset    <= desc_addr[MASK_BITS-1:0];
    req_count     <= (desc_len[MASK_BITS-1:0] == '0) ? desc_lines : desc_lines + 1'b1;
    // Zero remainder wraps to the top byte
    req_final_ptr <= desc_len[MASK_BITS-1:0] - 1'b1;
    req_dest      <= desc_accel_id;
    req_v         <= desc_valid;
    if (rst)
      req_v <= 1'b0;
  end

  assign req_onehot = ACCEL_COUNT'(1) << req_dest;
  assign req_last   = (req_count == line_cnt_t'(1));
  assign act_last   = (act_count[arb_enc] == line_cnt_t'(1));

  // Active table keeps what is left after each issued line
  always_ff @(posedge clk) begin
    if (req_v) begin
      act_addr[req_dest]      <= req_addr + 1'b1;
      act_count[req_dest]     <= req_count - 1'b1;
      act_final_ptr[req_dest] <= req_final_ptr;
      act_offset[req_dest]    <= req_offset;
    end else if (arb_valid) begin
      act_addr[arb_enc]  <= act_addr[arb_enc] + 1'b1;
      act_count[arb_enc] <= act_count[arb_enc] - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req_v && !req_last)
      act_v <= (act_v | req_onehot) & ~stop_r;
    else if (arb_valid && act_last)
      act_v <= act_v & ~arb_grant & ~stop_r;
    else
      act_v <= act_v & ~stop_r;
    if (rst)
      act_v <= '0;
  end

  // A new descriptor owns the read port for its first line
  assign arb_request = req_v ? '0 : (act_v & credit_ok & ~stop_r);

  rr_arbiter #(
    .ACCEL_COUNT (ACCEL_COUNT)
  ) i_rr_arbiter (
    .clk           (clk),
    .rst           (rst),
    .request       (arb_request),
    .grant         (arb_grant),
    .grant_valid   (arb_valid),
    .grant_encoded (arb_enc)
  );

  assign rd_line   = req_v ? req_addr : act_addr[arb_enc];
  assign rd_line_n = rd_line + 1'b1;
  assign req_ptr   = req_last ? req_final_ptr : '1;
  assign act_ptr   = act_last ? act_final_ptr[arb_enc] : '1;

  // Line L and L+1 always sit in opposite banks
  always_ff @(posedge clk) begin
    b1_rd_en   <= req_v | arb_valid;
    b2_rd_en   <= req_v | arb_valid;
    b1_rd_addr <= rd_line[0] ? rd_line_n[LINE_MSB:1] : rd_line[LINE_MSB:1];
    b2_rd_addr <= rd_line[0] ? rd_line[LINE_MSB:1] : rd_line_n[LINE_MSB:1];
    meta_s[0]  <= req_v ? {req_last, req_ptr, req_offset, rd_line[0], req_dest} :
                          {act_last, act_ptr, act_offset[arb_enc], rd_line[0], arb_enc};
    for (int s = 1; s < 4; s++)
      meta_s[s] <= meta_s[s-1];
    vld_s <= {vld_s[2:1], b1_rd_en};
    if (rst) begin
      b1_rd_en <= 1'b0;
      b2_rd_en <= 1'b0;
      vld_s    <= '0;
    end
  end

  // Meta layout is last, end pointer, offset, bank, destination
  assign {s2_offset, s2_bank} = meta_s[2][ID_WIDTH +: MASK_BITS+1];
  assign {s3_last, s3_ptr}    = meta_s[3][META_WIDTH-1 -: MASK_BITS+1];
  assign s3_dest              = meta_s[3][ID_WIDTH-1:0];

  // Odd start line means bank 2 holds the lower half
  assign pair_shifted = (s2_bank ? {b1_q, b2_q} : {b2_q, b1_q}) >> (8 * s2_offset);

  always_ff @(posedge clk) begin
    b1_q    <= b1_rd_data;
    b2_q    <= b2_rd_data;
    line_s3 <= pair_shifted[DATA_WIDTH-1:0];
  end

  assign done = m_tvalid & m_tlast & m_tready;

  always_ff @(posedge clk) begin
    stop_r <= stop_r | m_stop;
    if (desc_valid)
      stop_r[desc_accel_id] <= 1'b0;
    accel_busy <= (accel_busy | (req_v ? req_onehot : '0)) & ~stop_r & ~done;
    if (rst) begin
      stop_r     <= '0;
      accel_busy <= '0;
    end
  end

  for (genvar i = 0; i < ACCEL_COUNT; i++) begin : g_accel
    logic [CNT_WIDTH-1:0] credit;
    logic                 issued;
    logic                 fifo_valid;
    logic                 fifo_ready;
    logic                 out_ready;
    logic                 line_last;
    byte_ptr_t            end_ptr;
    byte_ptr_t            byte_ptr;
    line_t                fifo_line;
    logic [7:0]           tdata_q;
    logic                 tlast_q;
    logic                 tvalid_q;

    assign issued = (req_v && req_onehot[i]) || (arb_valid && arb_grant[i]);

    // Lines in flight plus lines buffered
    always_ff @(posedge clk) begin
      if (rst || stop_r[i])
        credit <= '0;
      else if (issued && !(fifo_valid && fifo_ready))
        credit <= credit + 1'b1;
      else if (!issued && fifo_valid && fifo_ready)
        credit <= credit - 1'b1;
    end

    assign credit_ok[i] = (credit < FIFO_LINES);

    line_fifo #(
      .FIFO_LINES (FIFO_LINES)
    ) i_line_fifo (
      .clk        (clk),
      .rst        (rst),
      .clear      (stop_r[i]),
      .din_valid  (vld_s[3] && (s3_dest == ID_WIDTH'(i))),
      .din        ({s3_last, s3_ptr, line_s3}),
      .dout_valid (fifo_valid),
      .dout       ({line_last, end_ptr, fifo_line}),
      .dout_ready (fifo_ready)
    );

    assign out_ready  = !tvalid_q || m_tready[i];
    assign fifo_ready = out_ready && (byte_ptr == end_ptr);

    always_ff @(posedge clk) begin
      if (fifo_valid && out_ready)
        byte_ptr <= (byte_ptr == end_ptr) ? '0 : byte_ptr + 1'b1;
      if (out_ready) begin
        tdata_q  <= fifo_line[8*byte_ptr +: 8];
        tlast_q  <= line_last && (byte_ptr == end_ptr);
        tvalid_q <= fifo_valid;
      end
      if (rst || m_stop[i] || stop_r[i]) begin
        byte_ptr <= '0;
        tvalid_q <= 1'b0;
      end
    end

    assign m_tdata[8*i +: 8] = tdata_q;
    assign m_tlast[i]        = tlast_q;
    assign m_tvalid[i]       = tvalid_q;
  end

  // A launched accelerator must have no live table entry
  assert property (@(posedge clk) disable iff (rst)
    req_v |-> !act_v[req_dest]);

endmodule

//--- accel_rd_dma/line_fifo.sv
`timescale 1ns/100ps

module line_fifo
  import dma_cfg_pkg::*;
#(
  parameter int  FIFO_LINES  = 2,
  localparam int ENTRY_WIDTH = 1 + MASK_BITS + DATA_WIDTH,
  localparam int PTR_WIDTH   = (FIFO_LINES > 1) ? $clog2(FIFO_LINES) : 1
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   clear,
  input  logic                   din_valid,
  input  logic [ENTRY_WIDTH-1:0] din,
  output logic                   dout_valid,
  output logic [ENTRY_WIDTH-1:0] dout,
  input  logic                   dout_ready
);

  logic [ENTRY_WIDTH-1:0]           mem [FIFO_LINES];
  logic [PTR_WIDTH-1:0]             wr_ptr;
  logic [PTR_WIDTH-1:0]             rd_ptr;
  logic [$clog2(FIFO_LINES+1)-1:0] count;
  logic                             rd;

  assign rd         = dout_valid && dout_ready;
  assign dout_valid = (count != '0);
  assign dout       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (din_valid)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (din_valid)
        wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_LINES - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd)
        rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_LINES - 1)) ? '0 : rd_ptr + 1'b1;
      case ({din_valid, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // Upstream credit keeps writes away from a full FIFO
  assert property (@(posedge clk) disable iff (rst)
    (din_valid && !clear) |-> (count < FIFO_LINES));

endmodule

//--- accel_rd_dma/rr_arbiter.sv
`timescale 1ns/100ps

module rr_arbiter #(
  parameter int  ACCEL_COUNT = 4,
  localparam int ID_WIDTH    = (ACCEL_COUNT > 1) ? $clog2(ACCEL_COUNT) : 1
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [ACCEL_COUNT-1:0] request,
  output logic [ACCEL_COUNT-1:0] grant,
  output logic                   grant_valid,
  output logic [ID_WIDTH-1:0]    grant_encoded
);

  logic [ID_WIDTH-1:0] last_winner;

  // Search starts one past the last winner
  always_comb begin
    int idx;
    grant         = '0;
    grant_valid   = 1'b0;
    grant_encoded = '0;
    for (int k = 1; k <= ACCEL_COUNT; k++) begin
      idx = (int'(last_winner) + k) % ACCEL_COUNT;
      if (!grant_valid && request[idx]) begin
        grant[idx]    = 1'b1;
        grant_valid   = 1'b1;
        grant_encoded = ID_WIDTH'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      last_winner <= ID_WIDTH'(ACCEL_COUNT - 1);
    else if (grant_valid)
      last_winner <= grant_encoded;
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

endmodule

//--- common/dma_cfg_pkg.sv
package dma_cfg_pkg;

  localparam int ADDR_WIDTH     = 10;
  localparam int LEN_WIDTH      = 8;
  localparam int KEEP_WIDTH     = 4;
  localparam int DATA_WIDTH     = 8 * KEEP_WIDTH;
  localparam int MASK_BITS      = $clog2(KEEP_WIDTH);

  // Width of the id field in the descriptor register
  localparam int DEST_MAX_WIDTH = 6;

  typedef logic [ADDR_WIDTH-1:0] byte_addr_t;
  typedef logic [LEN_WIDTH-1:0]  len_t;
  typedef logic [MASK_BITS-1:0]  byte_ptr_t;

  // One extra bit so the longest transfer still fits after rounding up
  typedef logic [LEN_WIDTH-MASK_BITS:0] line_cnt_t;

endpackage

//--- common/spm_pkg.sv
package spm_pkg;

  import dma_cfg_pkg::*;

  typedef logic [DATA_WIDTH-1:0] line_t;

  typedef logic [ADDR_WIDTH-MASK_BITS-1:0] line_addr_t;

  // Line address without its LSB, which selects the bank
  typedef logic [ADDR_WIDTH-MASK_BITS-2:0] bank_addr_t;

endpackage

//--- scratchpad_reader.f
common/dma_cfg_pkg.sv
common/spm_pkg.sv
accel_rd_dma/rr_arbiter.sv
accel_rd_dma/line_fifo.sv
accel_rd_dma/accel_rd_dma.sv
src/dual_bank_sram.sv
src/desc_regs.sv
src/scratchpad_reader.sv
test/tb_scratchpad_reader.sv

//--- src/desc_regs.sv
`timescale 1ns/100ps

module desc_regs
  import dma_cfg_pkg::*;
#(
  parameter int  ACCEL_COUNT = 4,
  localparam int ID_WIDTH    = (ACCEL_COUNT > 1) ? $clog2(ACCEL_COUNT) : 1
) (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   reg_we,
  input  logic [1:0]             reg_addr,
  input  logic [31:0]            reg_wdata,
  output logic [31:0]            reg_rdata,

  input  logic [ACCEL_COUNT-1:0] accel_busy,
  output logic [ID_WIDTH-1:0]    desc_accel_id,
  output byte_addr_t             desc_addr,
  output len_t                   desc_len,
  output logic                   desc_valid
);

  logic [DEST_MAX_WIDTH-1:0] id_field;

  assign id_field = reg_wdata[DEST_MAX_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (reg_we) begin
      case (reg_addr)
        2'd0:    desc_addr     <= reg_wdata[ADDR_WIDTH-1:0];
        2'd1:    desc_len      <= reg_wdata[LEN_WIDTH-1:0];
        2'd2:    desc_accel_id <= id_field[ID_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  // Writing the id register launches the descriptor
  always_ff @(posedge clk) begin
    if (rst)
      desc_valid <= 1'b0;
    else
      desc_valid <= reg_we && (reg_addr == 2'd2);
  end

  always_ff @(posedge clk) begin
    case (reg_addr)
      2'd0:    reg_rdata <= 32'(desc_addr);
      2'd1:    reg_rdata <= 32'(desc_len);
      2'd2:    reg_rdata <= 32'(desc_accel_id);
      default: reg_rdata <= 32'(accel_busy);
    endcase
  end

  // Host may only launch to an idle accelerator
  assert property (@(posedge clk) disable iff (rst)
    desc_valid |-> !accel_busy[desc_accel_id]);

endmodule

//--- src/dual_bank_sram.sv
`timescale 1ns/100ps

module dual_bank_sram
  import spm_pkg::*;
(
  input  logic       clk,

  input  logic       mem_wr_en,
  input  line_addr_t mem_wr_addr,
  input  line_t      mem_wr_data,

  input  bank_addr_t b1_rd_addr,
  input  logic       b1_rd_en,
  output line_t      b1_rd_data,
  input  bank_addr_t b2_rd_addr,
  input  logic       b2_rd_en,
  output line_t      b2_rd_data
);

  localparam int BANK_DEPTH = 2 ** $bits(bank_addr_t);

  line_t      bank1 [BANK_DEPTH];
  line_t      bank2 [BANK_DEPTH];
  bank_addr_t wr_row;

  assign wr_row = mem_wr_addr[$bits(line_addr_t)-1:1];

  // Even lines in bank 1, odd lines in bank 2
  always_ff @(posedge clk) begin
    if (mem_wr_en && !mem_wr_addr[0])
      bank1[wr_row] <= mem_wr_data;
    if (mem_wr_en && mem_wr_addr[0])
      bank2[wr_row] <= mem_wr_data;
  end

  always_ff @(posedge clk) begin
    if (b1_rd_en)
      b1_rd_data <= bank1[b1_rd_addr];
    if (b2_rd_en)
      b2_rd_data <= bank2[b2_rd_addr];
  end

endmodule

//--- src/scratchpad_reader.sv
`timescale 1ns/100ps

module scratchpad_reader
  import dma_cfg_pkg::*, spm_pkg::*;
#(
  parameter int ACCEL_COUNT = 4,
  parameter int FIFO_LINES  = 2
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     reg_we,
  input  logic [1:0]               reg_addr,
  input  logic [31:0]              reg_wdata,
  output logic [31:0]              reg_rdata,

  input  logic                     mem_wr_en,
  input  line_addr_t               mem_wr_addr,
  input  line_t                    mem_wr_data,

  output logic [ACCEL_COUNT*8-1:0] m_tdata,
  output logic [ACCEL_COUNT-1:0]   m_tlast,
  output logic [ACCEL_COUNT-1:0]   m_tvalid,
  input  logic [ACCEL_COUNT-1:0]   m_tready,
  input  logic [ACCEL_COUNT-1:0]   m_stop
);

  localparam int ID_WIDTH = (ACCEL_COUNT > 1) ? $clog2(ACCEL_COUNT) : 1;

  logic [ID_WIDTH-1:0]    desc_accel_id;
  byte_addr_t             desc_addr;
  len_t                   desc_len;
  logic                   desc_valid;
  logic [ACCEL_COUNT-1:0] accel_busy;

  bank_addr_t             b1_rd_addr;
  logic                   b1_rd_en;
  line_t                  b1_rd_data;
  bank_addr_t             b2_rd_addr;
  logic                   b2_rd_en;
  line_t                  b2_rd_data;

  desc_regs #(
    .ACCEL_COUNT (ACCEL_COUNT)
  ) i_desc_regs (
    .clk           (clk),
    .rst           (rst),
    .reg_we        (reg_we),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .reg_rdata     (reg_rdata),
    .accel_busy    (accel_busy),
    .desc_accel_id (desc_accel_id),
    .desc_addr     (desc_addr),
    .desc_len      (desc_len),
    .desc_valid    (desc_valid)
  );

  accel_rd_dma #(
    .ACCEL_COUNT (ACCEL_COUNT),
    .FIFO_LINES  (FIFO_LINES)
  ) i_accel_rd_dma (
    .clk           (clk),
    .rst           (rst),
    .desc_accel_id (desc_accel_id),
    .desc_addr     (desc_addr),
    .desc_len      (desc_len),
    .desc_valid    (desc_valid),
    .accel_busy    (accel_busy),
    .b1_rd_addr    (b1_rd_addr),
    .b1_rd_en      (b1_rd_en),
    .b1_rd_data    (b1_rd_data),
    .b2_rd_addr    (b2_rd_addr),
    .b2_rd_en      (b2_rd_en),
    .b2_rd_data    (b2_rd_data),
    .m_tdata       (m_tdata),
    .m_tlast       (m_tlast),
    .m_tvalid      (m_tvalid),
    .m_tready      (m_tready),
    .m_stop        (m_stop)
  );

  dual_bank_sram i_dual_bank_sram (
    .clk         (clk),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data),
    .b1_rd_addr  (b1_rd_addr),
    .b1_rd_en    (b1_rd_en),
    .b1_rd_data  (b1_rd_data),
    .b2_rd_addr  (b2_rd_addr),
    .b2_rd_en    (b2_rd_en),
    .b2_rd_data  (b2_rd_data)
  );

endmodule

//--- test/tb_scratchpad_reader.sv
`timescale 1ns/100ps

module tb_scratchpad_reader
  import dma_cfg_pkg::*, spm_pkg::*;
();

  localparam int ACCEL_COUNT     = 4;
  localparam int FIFO_LINES      = 2;
  localparam int MEM_BYTES       = 2 ** ADDR_WIDTH;
  localparam int LINE_COUNT      = MEM_BYTES / KEEP_WIDTH;
  localparam int QUEUE_DEPTH     = 256;
  localparam int MAX_LEN         = 64;
  localparam int NUM_DESC        = 42;
  localparam int WATCHDOG_CYCLES = NUM_DESC * MAX_LEN * ACCEL_COUNT * 40;

  logic                     clk;
  logic                     rst;
  logic                     reg_we;
  logic [1:0]               reg_addr;
  logic [31:0]              reg_wdata;
  logic [31:0]              reg_rdata;
  logic                     mem_wr_en;
  line_addr_t               mem_wr_addr;
  line_t                    mem_wr_data;
  logic [ACCEL_COUNT*8-1:0] m_tdata;
  logic [ACCEL_COUNT-1:0]   m_tlast;
  logic [ACCEL_COUNT-1:0]   m_tvalid;
  logic [ACCEL_COUNT-1:0]   m_tready;
  logic [ACCEL_COUNT-1:0]   m_stop;

  integer                   seed;
  integer                   ready_seed;
  int                       errors;
  logic [7:0]               mem_model [MEM_BYTES];
  // Each entry is {last, byte}
  logic [8:0]               exp_mem [ACCEL_COUNT][QUEUE_DEPTH];
  int                       exp_head [ACCEL_COUNT];
  int                       exp_tail [ACCEL_COUNT];
  logic [ACCEL_COUNT-1:0]   stopped;
  logic [ACCEL_COUNT-1:0]   ready_hold;
  logic                     throttle;

  scratchpad_reader #(
    .ACCEL_COUNT (ACCEL_COUNT),
    .FIFO_LINES  (FIFO_LINES)
  ) i_scratchpad_reader (
    .clk         (clk),
    .rst         (rst),
    .reg_we      (reg_we),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data),
    .m_tdata     (m_tdata),
    .m_tlast     (m_tlast),
    .m_tvalid    (m_tvalid),
    .m_tready    (m_tready),
    .m_stop      (m_stop)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  function automatic int pick_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic write_reg(input logic [1:0] addr, input int data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = 32'(data);
    step_cycle();
    reg_we    = 1'b0;
    reg_addr  = 2'd3;
  endtask

  task automatic fill_memory();
    line_t word;
    for (int l = 0; l < LINE_COUNT; l++) begin
      word        = $random(seed);
      mem_wr_en   = 1'b1;
      mem_wr_addr = line_addr_t'(l);
      mem_wr_data = word;
      for (int b = 0; b < KEEP_WIDTH; b++)
        mem_model[l * KEEP_WIDTH + b] = word[8*b +: 8];
      step_cycle();
    end
    mem_wr_en = 1'b0;
  endtask

  task automatic launch(input int id, input int addr, input int len);
    for (int k = 0; k < len; k++) begin
      exp_mem[id][exp_tail[id] % QUEUE_DEPTH] = {k == len - 1, mem_model[(addr + k) % MEM_BYTES]};
      exp_tail[id]++;
    end
    stopped[id] = 1'b0;
    write_reg(2'd0, addr);
    write_reg(2'd1, len);
    write_reg(2'd2, id);
  endtask

  task automatic check_busy_set(input int id);
    repeat (3) step_cycle();
    check_value($sformatf("reg_rdata[%0d]", id), 32'd1, reg_rdata[id]);
  endtask

  task automatic wait_idle(input int id);
    while (exp_head[id] != exp_tail[id])
      step_cycle();
    repeat (2) step_cycle();
    check_value($sformatf("reg_rdata[%0d]", id), 32'd0, reg_rdata[id]);
  endtask

  task automatic run_single(input int id, input int addr, input int len);
    launch(id, addr, len);
    check_busy_set(id);
    wait_idle(id);
  endtask

  task automatic run_round();
    int addr;
    int len;
    for (int id = 0; id < ACCEL_COUNT; id++) begin
      addr = pick_range(0, MEM_BYTES - 1);
      len  = pick_range(1, MAX_LEN);
      launch(id, addr, len);
    end
    for (int id = 0; id < ACCEL_COUNT; id++)
      wait_idle(id);
  endtask

  task automatic stop_midway(input int id);
    int addr;
    addr = pick_range(0, MEM_BYTES - 1);
    launch(id, addr, MAX_LEN);
    check_busy_set(id);
    while (exp_tail[id] - exp_head[id] > MAX_LEN - 8)
      step_cycle();
    // Hold tready low so no byte moves in the stop cycle
    ready_hold[id] = 1'b1;
    step_cycle();
    m_stop[id] = 1'b1;
    step_cycle();
    m_stop[id]     = 1'b0;
    ready_hold[id] = 1'b0;
    stopped[id]    = 1'b1;
    exp_head[id]   = exp_tail[id];
    repeat (10) step_cycle();
    check_value($sformatf("reg_rdata[%0d]", id), 32'd0, reg_rdata[id]);
  endtask

  // Ready pattern is picked at the edge and driven after it
  always @(posedge clk) begin
    logic [ACCEL_COUNT-1:0] next_ready;
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      if (ready_hold[i])
        next_ready[i] = 1'b0;
      else if (throttle)
        next_ready[i] = ($random(ready_seed) & 3) != 0;
      else
        next_ready[i] = 1'b1;
    end
    #2;
    m_tready = next_ready;
  end

  // Output monitor pops the model on every accepted byte
  always @(posedge clk) begin
    logic [8:0] expected;
    if (!rst) begin
      for (int i = 0; i < ACCEL_COUNT; i++) begin
        if (stopped[i] && m_tvalid[i]) begin
          $display("Accelerator %0d presented a valid byte after its stop at %0t", i, $time);
          errors++;
        end else if (m_tvalid[i] && m_tready[i]) begin
          if (exp_head[i] == exp_tail[i]) begin
            $display("Accelerator %0d delivered a byte with none expected at %0t", i, $time);
            errors++;
          end else begin
            expected = exp_mem[i][exp_head[i] % QUEUE_DEPTH];
            check_value($sformatf("m_tdata[%0d]", i), 32'(expected[7:0]), 32'(m_tdata[8*i +: 8]));
            check_value($sformatf("m_tlast[%0d]", i), 32'(expected[8]), 32'(m_tlast[i]));
            exp_head[i]++;
          end
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d errors so far", WATCHDOG_CYCLES, errors);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    seed        = 32'h8319;
    ready_seed  = 32'h8319;
    errors      = 0;
    rst         = 1'b1;
    reg_we      = 1'b0;
    reg_addr    = 2'd3;
    reg_wdata   = '0;
    mem_wr_en   = 1'b0;
    mem_wr_addr = '0;
    mem_wr_data = '0;
    m_tready    = '0;
    m_stop      = '0;
    stopped     = '0;
    ready_hold  = '0;
    throttle    = 1'b0;
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      exp_head[i] = 0;
      exp_tail[i] = 0;
    end
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    fill_memory();

    // Aligned reads, one line up to several lines
    for (int k = 0; k < 4; k++)
      run_single(0, pick_range(0, LINE_COUNT - 1) * KEEP_WIDTH, KEEP_WIDTH << k);

    // Unaligned addresses and lengths across bank boundaries
    for (int k = 0; k < 12; k++)
      run_single(pick_range(0, ACCEL_COUNT - 1), pick_range(0, MEM_BYTES - 1),
                 pick_range(1, MAX_LEN));

    repeat (3) run_round();

    throttle = 1'b1;
    repeat (3) run_round();

    stop_midway(2);
    run_single(2, pick_range(0, MEM_BYTES - 1), pick_range(1, MAX_LEN));

    throttle = 1'b0;
    repeat (20) step_cycle();
    $display("Run complete with %0d errors", errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
